/* flist.f */
src/pea_pkg.sv
src/pea_cfg_ctrl.sv
src/pea_act_feeder.sv
src/pea_mac_pe.sv
src/pea_out_drain.sv
src/pea_top.sv
bench/tb_pea_sva.sv
bench/tb_pea.sv

/* run_sim.sh */
#!/bin/sh
# Builds tb_pea with Verilator, runs it and passes only on the pass message
verilator --binary --timing --assert -f flist.f --top-module tb_pea -o tb_pea \
    && out="$(./obj_dir/tb_pea +verilator+error+limit+100)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/tb_pea.sv */
//==========================================================================
// Testbench for the PE array, three frames of random data with back-pressure
// Model assumes valid convolution, PE_NUM 4 and KERNEL_TAPS 3
//==========================================================================
`timescale 1ns/10ps

module tb_pea;
    import pea_pkg::*;

    localparam int PE_NUM      = 4;
    localparam int KERNEL_TAPS = 3;
    localparam int CH_W        = $clog2(PE_NUM);
    localparam int MAX_LEN     = 40;
    localparam int FRAMES      = 3;
    localparam int RST_CYC     = 16;
    localparam int TIMEOUT     = FRAMES * (MAX_LEN + 12) * PE_NUM * 4 + RST_CYC;
    // Per frame scale, bias and shift, the last one saturates
    localparam int MUL_TAB [FRAMES]  = '{1, 5, 200};
    localparam int BIAS_TAB [FRAMES] = '{-40, 300, 0};
    localparam int SHF_TAB [FRAMES]  = '{7, 10, 2};

    typedef struct packed {
        logic            lst;
        logic [CH_W-1:0] ch;
        out_t            dat;
    } word_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            cfg_vld;
    logic            cfg_rdy;
    pea_cfg_t        cfg;
    logic            wei_vld;
    logic            wei_rdy;
    wei_t            wei_dat;
    logic            act_vld;
    logic            act_rdy;
    act_t            act_dat;
    logic            out_vld;
    logic            out_rdy = 1'b0;
    out_t            out_dat;
    logic [CH_W-1:0] out_ch;
    logic            out_lst;

    logic [31:0] stim_lfsr;
    logic [31:0] rdy_lfsr = 32'h768b;
    wei_t        wei_mem [PE_NUM * KERNEL_TAPS];
    act_t        act_mem [MAX_LEN];
    word_t       exp_q [$];
    word_t       exp_w;
    logic        busy = 1'b0;
    logic        lst_d = 1'b0;
    int          err_main = 0;
    int          err_mon = 0;
    int          chk_cnt = 0;
    int          sat_hi = 0;
    int          sat_lo = 0;
    int          cyc_cnt = 0;
    int          sva_fails;

    pea_top #(
        .PE_NUM      (PE_NUM),
        .KERNEL_TAPS (KERNEL_TAPS)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_vld_i (cfg_vld),
        .cfg_rdy_o (cfg_rdy),
        .cfg_i     (cfg),
        .wei_vld_i (wei_vld),
        .wei_rdy_o (wei_rdy),
        .wei_dat_i (wei_dat),
        .act_vld_i (act_vld),
        .act_rdy_o (act_rdy),
        .act_dat_i (act_dat),
        .out_vld_o (out_vld),
        .out_rdy_i (out_rdy),
        .out_dat_o (out_dat),
        .out_ch_o  (out_ch),
        .out_lst_o (out_lst)
    );

    bind pea_out_drain tb_pea_sva #(
        .PE_NUM (PE_NUM)
    ) u_sva (
        .clk    (clk),
        .rst_n  (rst_n),
        .done_i (frame_done_o),
        .vld_i  (out_vld_o),
        .rdy_i  (out_rdy_i),
        .dat_i  (out_dat_o),
        .ch_i   (out_ch_o),
        .lst_i  (out_lst_o)
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    task automatic report_err(input string msg);
        $display("error %0t: %s", $time, msg);
    endtask

    //==========================================================================
    // Reference model, one word per channel for every full window
    //==========================================================================
    task automatic expect_frame(input pea_cfg_t c, input logic count_sat);
        longint dot;
        longint v;
        word_t  w;
        for (int p = 0; p <= int'(c.len) - KERNEL_TAPS; p++) begin
            for (int ch = 0; ch < PE_NUM; ch++) begin
                dot = 0;
                for (int k = 0; k < KERNEL_TAPS; k++) begin
                    dot += longint'(wei_mem[ch * KERNEL_TAPS + k]) * longint'(act_mem[p + k]);
                end
                v = (dot * longint'(c.mul) + longint'(c.bias)) >>> c.shift;
                if (v > 127) begin
                    w.dat = out_t'(127);
                    sat_hi += int'(count_sat);
                end else if (v < -128) begin
                    w.dat = out_t'(-128);
                    sat_lo += int'(count_sat);
                end else begin
                    w.dat = out_t'(v);
                end
                w.ch  = CH_W'(ch);
                w.lst = (p == int'(c.len) - KERNEL_TAPS) && (ch == PE_NUM - 1);
                exp_q.push_back(w);
            end
        end
    endtask

    task automatic run_frame(input int f);
        logic [31:0] r;
        pea_cfg_t    c;
        int          i;
        draw(6, r);
        c.len   = len_t'(8 + r % 33);
        c.mul   = mul_t'(MUL_TAB[f]);
        c.bias  = acc_t'(BIAS_TAB[f]);
        c.shift = shf_t'(SHF_TAB[f]);
        for (int j = 0; j < PE_NUM * KERNEL_TAPS; j++) begin
            draw(8, r);
            wei_mem[j] = wei_t'(r[7:0]);
        end
        for (int j = 0; j < int'(c.len); j++) begin
            draw(8, r);
            act_mem[j] = act_t'(r[7:0]);
        end
        expect_frame(c, f == FRAMES - 1);
        // Waits out the previous frame
        cfg_vld <= 1'b1;
        cfg     <= c;
        @(posedge clk);
        while (!cfg_rdy) begin
            @(posedge clk);
        end
        cfg_vld <= 1'b0;
        i = 0;
        while (i < PE_NUM * KERNEL_TAPS) begin
            wei_vld <= 1'b1;
            wei_dat <= wei_mem[i];
            @(posedge clk);
            if (wei_rdy) begin
                i++;
            end
        end
        wei_vld <= 1'b0;
        // Activations with random gaps
        i = 0;
        while (i < int'(c.len)) begin
            draw(2, r);
            act_vld <= (r[1:0] != 2'b00);
            act_dat <= act_mem[i];
            @(posedge clk);
            if (act_vld && act_rdy) begin
                i++;
            end
        end
        act_vld <= 1'b0;
    endtask

    //==========================================================================
    // Output monitor
    //==========================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(busy && cfg_rdy)) else begin
                err_mon++;
                report_err("cfg_rdy_o high during LOAD or CONV");
            end
            assert (!lst_d || cfg_rdy) else begin
                err_mon++;
                report_err("cfg_rdy_o low after the last output word");
            end
            lst_d <= 1'b0;
            if (cfg_vld && cfg_rdy) begin
                busy <= 1'b1;
            end
            if (out_vld && out_rdy) begin
                chk_cnt++;
                assert (exp_q.size() > 0) else begin
                    err_mon++;
                    report_err("more output words than expected");
                end
                if (exp_q.size() > 0) begin
                    exp_w = exp_q.pop_front();
                    assert (out_dat == exp_w.dat && out_ch == exp_w.ch && out_lst == exp_w.lst)
                    else begin
                        err_mon++;
                        report_err($sformatf("got ch %0d data %0d last %0b, expected %0d %0d %0b",
                            out_ch, out_dat, out_lst, exp_w.ch, exp_w.dat, exp_w.lst));
                    end
                end
                if (out_lst) begin
                    busy  <= 1'b0;
                    lst_d <= 1'b1;
                end
            end
        end
    end

    // Sink back-pressure and run limit
    always @(posedge clk) begin
        rdy_lfsr = lfsr_next(rdy_lfsr);
        rdy_lfsr = lfsr_next(rdy_lfsr);
        out_rdy <= (rdy_lfsr[1:0] != 2'b00);
        cyc_cnt++;
        if (cyc_cnt >= TIMEOUT) begin
            $display("Run stopped after %0d cycles, output stream never finished", cyc_cnt);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        stim_lfsr = 32'h768b;
        rst_n     = 1'b0;
        cfg_vld   = 1'b0;
        cfg       = '0;
        wei_vld   = 1'b0;
        wei_dat   = '0;
        act_vld   = 1'b0;
        act_dat   = '0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (cfg_rdy && !wei_rdy && !act_rdy && !out_vld && !out_lst) else begin
            err_main++;
            report_err("ports not idle after reset");
        end
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (sat_hi > 0 && sat_lo > 0) else begin
            err_main++;
            report_err("large-scale frame did not reach both clamp limits");
        end
        sva_fails = UUT.u_drain.u_sva.fail_cnt;
        $display("checks %0d, errors %0d, protocol assertion failures %0d",
            chk_cnt, err_main + err_mon, sva_fails);
        if (err_main + err_mon + sva_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* bench/tb_pea_sva.sv */
//==========================================================================
// Output stream protocol checks, bound into the drain
// Rows are PE_NUM words long and always start at channel 0
//==========================================================================
`timescale 1ns/10ps

module tb_pea_sva #(
    parameter int  PE_NUM = 4,
    localparam int CH_W   = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
    input logic            clk,
    input logic            rst_n,
    input logic            done_i,
    input logic            vld_i,
    input logic            rdy_i,
    input pea_pkg::out_t   dat_i,
    input logic [CH_W-1:0] ch_i,
    input logic            lst_i
);
    int fail_cnt = 0;

    // Word held while the sink stalls
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        vld_i && !rdy_i |=> vld_i && $stable(dat_i) && $stable(ch_i) && $stable(lst_i))
    else begin
        fail_cnt++;
        $error("output word changed while out_rdy_i was low");
    end

    // Channels step by one inside a row
    step_a: assert property (@(posedge clk) disable iff (!rst_n)
        vld_i && rdy_i && (ch_i != CH_W'(PE_NUM - 1)) |=> vld_i && (ch_i == $past(ch_i) + 1'b1))
    else begin
        fail_cnt++;
        $error("channel index did not advance by one");
    end

    // Nothing left in the pipeline once the frame has ended
    end_a: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !vld_i)
    else begin
        fail_cnt++;
        $error("output still valid after the frame end");
    end

endmodule

/* src/pea_top.sv */
//==========================================================================
// 1-D convolution PE array, one PE per output channel
// Frame order is config, PE_NUM*KERNEL_TAPS weights, then len activations
//==========================================================================
`timescale 1ns/10ps

module pea_top #(
    parameter int  PE_NUM      = 4,
    parameter int  KERNEL_TAPS = 3,
    localparam int CH_W        = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_vld_i,
    output logic              cfg_rdy_o,
    input  pea_pkg::pea_cfg_t cfg_i,
    input  logic              wei_vld_i,
    output logic              wei_rdy_o,
    input  pea_pkg::wei_t     wei_dat_i,
    input  logic              act_vld_i,
    output logic              act_rdy_o,
    input  pea_pkg::act_t     act_dat_i,
    output logic              out_vld_o,
    input  logic              out_rdy_i,
    output pea_pkg::out_t     out_dat_o,
    output logic [CH_W-1:0]   out_ch_o,
    output logic              out_lst_o
);
    import pea_pkg::*;

    localparam int TAP_W = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1;

    pea_state_e             state;
    pea_cfg_t               cfg;
    logic                   load_done;
    logic                   frame_done;
    logic                   adv;
    logic                   wei_we;
    logic [CH_W-1:0]        wei_pe;
    logic [TAP_W-1:0]       wei_tap;
    wei_t                   wei;
    logic                   win_vld;
    logic                   win_lst;
    act_t [KERNEL_TAPS-1:0] win;
    logic [PE_NUM-1:0]      pe_vld;
    logic [PE_NUM-1:0]      pe_lst;
    out_t [PE_NUM-1:0]      pe_res;

    pea_cfg_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld_i    (cfg_vld_i),
        .cfg_rdy_o    (cfg_rdy_o),
        .cfg_i        (cfg_i),
        .load_done_i  (load_done),
        .frame_done_i (frame_done),
        .state_o      (state),
        .cfg_o        (cfg)
    );

    pea_act_feeder #(
        .PE_NUM      (PE_NUM),
        .KERNEL_TAPS (KERNEL_TAPS)
    ) u_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_i     (state),
        .len_i       (cfg.len),
        .adv_i       (adv),
        .wei_vld_i   (wei_vld_i),
        .wei_rdy_o   (wei_rdy_o),
        .wei_dat_i   (wei_dat_i),
        .act_vld_i   (act_vld_i),
        .act_rdy_o   (act_rdy_o),
        .act_dat_i   (act_dat_i),
        .wei_we_o    (wei_we),
        .wei_pe_o    (wei_pe),
        .wei_tap_o   (wei_tap),
        .wei_o       (wei),
        .load_done_o (load_done),
        .win_vld_o   (win_vld),
        .win_lst_o   (win_lst),
        .win_o       (win)
    );

    //==========================================================================
    // PE row
    //==========================================================================
    generate
        for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
            pea_mac_pe #(
                .PE_NUM      (PE_NUM),
                .KERNEL_TAPS (KERNEL_TAPS),
                .PE_ID       (g)
            ) u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .adv_i     (adv),
                .wei_we_i  (wei_we),
                .wei_pe_i  (wei_pe),
                .wei_tap_i (wei_tap),
                .wei_i     (wei),
                .win_vld_i (win_vld),
                .win_lst_i (win_lst),
                .win_i     (win),
                .mul_i     (cfg.mul),
                .bias_i    (cfg.bias),
                .shift_i   (cfg.shift),
                .res_vld_o (pe_vld[g]),
                .res_lst_o (pe_lst[g]),
                .res_o     (pe_res[g])
            );
        end
    endgenerate

    pea_out_drain #(
        .PE_NUM (PE_NUM)
    ) u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_vld_i    (pe_vld),
        .res_lst_i    (pe_lst),
        .res_i        (pe_res),
        .adv_o        (adv),
        .frame_done_o (frame_done),
        .out_vld_o    (out_vld_o),
        .out_rdy_i    (out_rdy_i),
        .out_dat_o    (out_dat_o),
        .out_ch_o     (out_ch_o),
        .out_lst_o    (out_lst_o)
    );

endmodule

/* src/pea_out_drain.sv */
//==========================================================================
// Row buffer that serializes one result per channel, channel 0 first
// All PEs run in lockstep, so PE 0 flags stand for the whole row
//==========================================================================
`timescale 1ns/10ps

module pea_out_drain #(
    parameter int  PE_NUM = 4,
    localparam int CH_W   = (PE_NUM > 1) ? $clog2(PE_NUM) : 1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [PE_NUM-1:0]          res_vld_i,
    input  logic [PE_NUM-1:0]          res_lst_i,
    input  pea_pkg::out_t [PE_NUM-1:0] res_i,
    output logic                       adv_o,
    output logic                       frame_done_o,
    output logic                       out_vld_o,
    input  logic                       out_rdy_i,
    output pea_pkg::out_t              out_dat_o,
    output logic [CH_W-1:0]            out_ch_o,
    output logic                       out_lst_o
);
    import pea_pkg::*;

    out_t [PE_NUM-1:0] row_q;
    logic              row_vld;
    logic              row_lst;
    logic [CH_W-1:0]   ch_q;
    logic              ch_end;
    logic              out_fire;

    assign ch_end   = (ch_q == CH_W'(PE_NUM - 1));
    assign out_fire = out_vld_o && out_rdy_i;

    // Advance when the buffer is empty or its final word leaves
    assign adv_o = !row_vld || (out_fire && ch_end);

    assign out_vld_o    = row_vld;
    assign out_dat_o    = row_q[ch_q];
    assign out_ch_o     = ch_q;
    assign out_lst_o    = row_vld && row_lst && ch_end;
    assign frame_done_o = out_fire && out_lst_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_vld <= 1'b0;
            row_lst <= 1'b0;
        end else if (adv_o) begin
            row_vld <= res_vld_i[0];
            row_lst <= res_vld_i[0] && res_lst_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (adv_o && res_vld_i[0]) begin
            row_q <= res_i;
        end
    end

    // Channel index, back to 0 after the row's last word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_q <= '0;
        end else if (out_fire) begin
            if (ch_end) begin
                ch_q <= '0;
            end else begin
                ch_q <= ch_q + 1'b1;
            end
        end
    end

endmodule

/* src/pea_mac_pe.sv */
//==========================================================================
// One output channel, dot product then requantization to int8
// Two stages, both hold while adv_i is low
//==========================================================================
`timescale 1ns/10ps

module pea_mac_pe #(
    parameter int  PE_NUM      = 4,
    parameter int  KERNEL_TAPS = 3,
    parameter int  PE_ID       = 0,
    localparam int CH_W        = (PE_NUM > 1) ? $clog2(PE_NUM) : 1,
    localparam int TAP_W       = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            adv_i,
    input  logic                            wei_we_i,
    input  logic [CH_W-1:0]                 wei_pe_i,
    input  logic [TAP_W-1:0]                wei_tap_i,
    input  pea_pkg::wei_t                   wei_i,
    input  logic                            win_vld_i,
    input  logic                            win_lst_i,
    input  pea_pkg::act_t [KERNEL_TAPS-1:0] win_i,
    input  pea_pkg::mul_t                   mul_i,
    input  pea_pkg::acc_t                   bias_i,
    input  pea_pkg::shf_t                   shift_i,
    output logic                            res_vld_o,
    output logic                            res_lst_o,
    output pea_pkg::out_t                   res_o
);
    import pea_pkg::*;

    wei_t [KERNEL_TAPS-1:0] wei_q;
    acc_t                   dot;
    acc_t                   s1_acc;
    logic                   s1_vld;
    logic                   s1_lst;
    scl_t                   scaled;
    scl_t                   shifted;

    // Clamp to the int8 range
    function automatic out_t sat8(scl_t v);
        if (v > 32'sd127) begin
            return 8'sd127;
        end else if (v < -32'sd128) begin
            return -8'sd128;
        end
        return out_t'(v);
    endfunction

    // Own taps only
    always_ff @(posedge clk) begin
        if (wei_we_i && (wei_pe_i == CH_W'(PE_ID))) begin
            wei_q[wei_tap_i] <= wei_i;
        end
    end

    // Tap k weights sample k of the window
    always_comb begin
        dot = '0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            dot = dot + acc_t'(wei_q[k]) * acc_t'(win_i[k]);
        end
    end

    assign scaled  = scl_t'(s1_acc) * scl_t'(mul_i) + scl_t'(bias_i);
    assign shifted = scaled >>> shift_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld    <= 1'b0;
            s1_lst    <= 1'b0;
            res_vld_o <= 1'b0;
            res_lst_o <= 1'b0;
        end else if (adv_i) begin
            s1_vld    <= win_vld_i;
            s1_lst    <= win_lst_i;
            res_vld_o <= s1_vld;
            res_lst_o <= s1_lst;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i && win_vld_i) begin
            s1_acc <= dot;
        end
        if (adv_i && s1_vld) begin
            res_o <= sat8(shifted);
        end
    end

endmodule

/* src/pea_act_feeder.sv */
//==========================================================================
// Weight router and activation window, valid convolution only
// Expects exactly PE_NUM*KERNEL_TAPS weights and len >= KERNEL_TAPS samples
//==========================================================================
`timescale 1ns/10ps

module pea_act_feeder #(
    parameter int  PE_NUM      = 4,
    parameter int  KERNEL_TAPS = 3,
    localparam int CH_W        = (PE_NUM > 1) ? $clog2(PE_NUM) : 1,
    localparam int TAP_W       = (KERNEL_TAPS > 1) ? $clog2(KERNEL_TAPS) : 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  pea_pkg::pea_state_e             state_i,
    input  pea_pkg::len_t                   len_i,
    input  logic                            adv_i,
    input  logic                            wei_vld_i,
    output logic                            wei_rdy_o,
    input  pea_pkg::wei_t                   wei_dat_i,
    input  logic                            act_vld_i,
    output logic                            act_rdy_o,
    input  pea_pkg::act_t                   act_dat_i,
    output logic                            wei_we_o,
    output logic [CH_W-1:0]                 wei_pe_o,
    output logic [TAP_W-1:0]                wei_tap_o,
    output pea_pkg::wei_t                   wei_o,
    output logic                            load_done_o,
    output logic                            win_vld_o,
    output logic                            win_lst_o,
    output pea_pkg::act_t [KERNEL_TAPS-1:0] win_o
);
    import pea_pkg::*;

    logic                   in_load;
    logic                   in_conv;
    logic                   wei_fire;
    logic                   act_fire;
    logic                   tap_end;
    logic                   pe_end;
    logic [CH_W-1:0]        pe_cnt;
    logic [TAP_W-1:0]       tap_cnt;
    len_t                   smp_cnt;
    act_t [KERNEL_TAPS-1:0] win_q;

    assign in_load = (state_i == PEA_LOAD);
    assign in_conv = (state_i == PEA_CONV);

    //==========================================================================
    // Weight routing, word j goes to PE j/KERNEL_TAPS, tap j%KERNEL_TAPS
    //==========================================================================
    assign wei_rdy_o   = in_load;
    assign wei_fire    = wei_vld_i && wei_rdy_o;
    assign tap_end     = (tap_cnt == TAP_W'(KERNEL_TAPS - 1));
    assign pe_end      = (pe_cnt == CH_W'(PE_NUM - 1));
    assign wei_we_o    = wei_fire;
    assign wei_pe_o    = pe_cnt;
    assign wei_tap_o   = tap_cnt;
    assign wei_o       = wei_dat_i;
    assign load_done_o = wei_fire && tap_end && pe_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt <= '0;
            pe_cnt  <= '0;
        end else if (!in_load) begin
            tap_cnt <= '0;
            pe_cnt  <= '0;
        end else if (wei_fire) begin
            if (tap_end) begin
                tap_cnt <= '0;
                pe_cnt  <= pe_cnt + 1'b1;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    //==========================================================================
    // Activation window
    //==========================================================================
    // Stops taking samples once len of them are in, and on any stall
    assign act_rdy_o = in_conv && adv_i && (smp_cnt != len_i);
    assign act_fire  = act_vld_i && act_rdy_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smp_cnt <= '0;
        end else if (!in_conv) begin
            smp_cnt <= '0;
        end else if (act_fire) begin
            smp_cnt <= smp_cnt + 1'b1;
        end
    end

    // Oldest sample at index 0, newest enters at the top
    always_ff @(posedge clk) begin
        if (act_fire) begin
            for (int k = 0; k < KERNEL_TAPS - 1; k++) begin
                win_q[k] <= win_q[k+1];
            end
            win_q[KERNEL_TAPS-1] <= act_dat_i;
        end
    end

    // Window flags follow the pipeline advance, a stall cycle yields a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_vld_o <= 1'b0;
            win_lst_o <= 1'b0;
        end else if (adv_i) begin
            win_vld_o <= act_fire && (smp_cnt >= len_t'(KERNEL_TAPS - 1));
            win_lst_o <= act_fire && (len_t'(smp_cnt + 1'b1) == len_i);
        end
    end

    assign win_o = win_q;

endmodule

/* src/pea_cfg_ctrl.sv */
//==========================================================================
// Frame controller, one config per frame, accepted only while idle
// Phases IDLE, LOAD, CONV; LOAD always continues into CONV
//==========================================================================
`timescale 1ns/10ps

module pea_cfg_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld_i,
    output logic                cfg_rdy_o,
    input  pea_pkg::pea_cfg_t   cfg_i,
    input  logic                load_done_i,
    input  logic                frame_done_i,
    output pea_pkg::pea_state_e state_o,
    output pea_pkg::pea_cfg_t   cfg_o
);
    import pea_pkg::*;

    pea_state_e state_q;
    pea_state_e state_d;
    pea_cfg_t   cfg_q;
    logic       cfg_acc;

    // Ready doubles as the idle indication
    assign cfg_rdy_o = (state_q == PEA_IDLE);
    assign cfg_acc   = cfg_vld_i && cfg_rdy_o;
    assign state_o   = state_q;
    assign cfg_o     = cfg_q;

    //==========================================================================
    // Phase FSM
    //==========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            PEA_IDLE: begin
                if (cfg_acc) begin
                    state_d = PEA_LOAD;
                end
            end
            PEA_LOAD: begin
                if (load_done_i) begin
                    state_d = PEA_CONV;
                end
            end
            PEA_CONV: begin
                // Frame ends on the final output handshake
                if (frame_done_i) begin
                    state_d = PEA_IDLE;
                end
            end
            default: begin
                state_d = PEA_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PEA_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Config stays put for the whole frame
    always_ff @(posedge clk) begin
        if (cfg_acc) begin
            cfg_q <= cfg_i;
        end
    end

endmodule

/* src/pea_pkg.sv */
//==========================================================================
// Shared types of the 1-D convolution PE array
// Accumulator and scaled widths assume short kernels and 8-bit samples
//==========================================================================
package pea_pkg;

    // Data path widths
    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  wei_t;
    typedef logic signed [23:0] acc_t;
    typedef logic signed [31:0] scl_t;
    typedef logic signed [7:0]  out_t;

    // Configuration fields
    typedef logic [9:0]         len_t;
    typedef logic [7:0]         mul_t;
    typedef logic [3:0]         shf_t;

    // 46 bits, latched once per frame
    typedef struct packed {
        len_t len;
        mul_t mul;
        acc_t bias;
        shf_t shift;
    } pea_cfg_t;

    typedef enum logic [1:0] {
        PEA_IDLE = 2'd0,
        PEA_LOAD = 2'd1,
        PEA_CONV = 2'd2
    } pea_state_e;

endpackage
